//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_decode_top
FILELIST  ?= decode_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, write $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- decode_top.f
hw/mips_isa_pkg.sv
hw/mips_pipe_pkg.sv
hw/if_id_reg.sv
hw/register_file.sv
hw/control_unit.sv
hw/instruction_decode.sv
hw/id_ex_reg.sv
hw/decode_top.sv
tests/decode_sva.sv
tests/tb_decode_top.sv

//--- hw/control_unit.sv
`timescale 1ns/10ps

module control_unit
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  opcode_t i_opcode,
    input  funct_t  i_funct,
    output ctrl_t   o_ctrl,
    output logic    o_zero_ext,
    output logic    o_illegal
);

    always_comb begin
        o_ctrl     = '0;
        o_zero_ext = 1'b0;
        o_illegal  = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                case (i_funct)
                    FN_ADD: o_ctrl.alu_op = ALU_ADD;
                    FN_SUB: o_ctrl.alu_op = ALU_SUB;
                    FN_AND: o_ctrl.alu_op = ALU_AND;
                    FN_OR:  o_ctrl.alu_op = ALU_OR;
                    FN_SLT: o_ctrl.alu_op = ALU_SLT;
                    FN_SLL: o_ctrl.alu_op = ALU_SLL;   // also the nop
                    FN_SRL: o_ctrl.alu_op = ALU_SRL;
                    FN_JR: begin
                        o_ctrl          = '0;
                        o_ctrl.jump_reg = 1'b1;
                    end
                    default: begin
                        o_ctrl    = '0;
                        o_illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDI, OP_SLTI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = (i_opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_LUI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_zero_ext       = 1'b1;
                if (i_opcode == OP_ANDI) begin
                    o_ctrl.alu_op = ALU_AND;
                end else if (i_opcode == OP_ORI) begin
                    o_ctrl.alu_op = ALU_OR;
                end else begin
                    o_ctrl.alu_op = ALU_LUI;
                end
            end
            OP_LW: begin
                o_ctrl.alu_src    = 1'b1;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.alu_op     = ALU_ADD;   // base + offset
            end
            OP_SW: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                o_ctrl.alu_op    = ALU_ADD;
            end
            OP_BEQ, OP_BNE: begin
                o_ctrl.branch    = 1'b1;
                o_ctrl.branch_ne = (i_opcode == OP_BNE);
                o_ctrl.alu_op    = ALU_SUB;    // compare by subtract
            end
            OP_J: begin
                o_ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                // return address goes to r31 via rd
                o_ctrl.jump      = 1'b1;
                o_ctrl.link      = 1'b1;
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- hw/decode_top.sv
`timescale 1ns/10ps

module decode_top
    import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
    parameter bit WB_BYPASS = 1'b1
)(
    input  logic      clk,
    input  logic      i_rst_n,
    input  fetch_t    i_fetch,
    input  logic      i_stall,
    input  logic      i_flush,
    input  logic      i_wb_en,
    input  reg_addr_t i_wb_addr,
    input  word_t     i_wb_data,
    output id_ex_t    o_id_ex
);

    fetch_t ifid;   // registered fetch
    id_ex_t dec;    // combinational decode result

    if_id_reg u_if_id (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_fetch (i_fetch),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .o_fetch (ifid)
    );

    instruction_decode #(
        .WB_BYPASS (WB_BYPASS)
    ) u_decode (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_fetch   (ifid),
        .i_wb_en   (i_wb_en),
        .i_wb_addr (i_wb_addr),
        .i_wb_data (i_wb_data),
        .o_dec     (dec)
    );

    id_ex_reg u_id_ex (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_dec   (dec),
        .i_stall (i_stall),
        .o_id_ex (o_id_ex)
    );

endmodule

//--- hw/id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg
    import mips_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  id_ex_t i_dec,
    input  logic   i_stall,
    output id_ex_t o_id_ex
);

    // nothing issues, all control inactive
    localparam id_ex_t BUBBLE = '0;

    id_ex_t id_ex_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            id_ex_q <= BUBBLE;
        end else if (i_stall) begin
            id_ex_q <= BUBBLE;   // one bubble per stalled cycle
        end else begin
            id_ex_q <= i_dec;
        end
    end

    assign o_id_ex = id_ex_q;

endmodule

//--- hw/if_id_reg.sv
`timescale 1ns/10ps

module if_id_reg
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  fetch_t i_fetch,
    input  logic   i_stall,
    input  logic   i_flush,
    output fetch_t o_fetch
);

    localparam fetch_t NOP_FETCH = '{instr: NOP_WORD, pc4: 32'h0000_0000};

    fetch_t fetch_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fetch_q <= NOP_FETCH;
        end else if (i_stall) begin
            fetch_q <= fetch_q;      // hold wins over flush
        end else if (i_flush) begin
            fetch_q <= NOP_FETCH;
        end else begin
            fetch_q <= i_fetch;
        end
    end

    assign o_fetch = fetch_q;

endmodule

//--- hw/instruction_decode.sv
`timescale 1ns/10ps

module instruction_decode
    import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
    parameter bit WB_BYPASS = 1'b1
)(
    input  logic      clk,
    input  logic      i_rst_n,
    input  fetch_t    i_fetch,
    input  logic      i_wb_en,
    input  reg_addr_t i_wb_addr,
    input  word_t     i_wb_data,
    output id_ex_t    o_dec
);

    localparam reg_addr_t LINK_REG = 5'd31;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    shamt;
    imm16_t    imm;
    jtarget_t  jidx;
    word_t     imm_sext;
    word_t     rd_data_a;
    word_t     rd_data_b;
    ctrl_t     ctrl;
    logic      zero_ext;
    logic      illegal;

    assign opcode = opcode_t'(i_fetch.instr[31:26]);
    assign rs     = i_fetch.instr[25:21];
    assign rt     = i_fetch.instr[20:16];
    assign rd     = i_fetch.instr[15:11];
    assign shamt  = i_fetch.instr[10:6];
    assign funct  = funct_t'(i_fetch.instr[5:0]);
    assign imm    = i_fetch.instr[15:0];
    assign jidx   = i_fetch.instr[25:0];

    assign imm_sext = {{16{imm[15]}}, imm};

    register_file #(
        .WB_BYPASS (WB_BYPASS)
    ) u_regfile (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_we       (i_wb_en),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data),
        .i_rd_addr1 (rs),
        .i_rd_addr2 (rt),
        .o_rd_data1 (rd_data_a),
        .o_rd_data2 (rd_data_b)
    );

    control_unit u_ctrl (
        .i_opcode   (opcode),
        .i_funct    (funct),
        .o_ctrl     (ctrl),
        .o_zero_ext (zero_ext),
        .o_illegal  (illegal)
    );

    always_comb begin
        o_dec           = '0;
        o_dec.ctrl      = ctrl;
        o_dec.illegal   = illegal;
        o_dec.rs        = rs;
        o_dec.rt        = rt;
        o_dec.rd        = (opcode == OP_JAL) ? LINK_REG : rd;
        o_dec.shamt     = shamt;
        o_dec.rd_data_a = rd_data_a;
        o_dec.rd_data_b = rd_data_b;
        o_dec.imm_ext   = zero_ext ? {16'h0000, imm} : imm_sext;
        // branch offset is always signed, even next to a zero-ext op
        o_dec.br_target = i_fetch.pc4 + {imm_sext[29:0], 2'b00};
        o_dec.j_target  = {i_fetch.pc4[31:28], jidx, 2'b00};
        o_dec.pc4       = i_fetch.pc4;
    end

endmodule

//--- hw/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;      // data or instruction word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jtarget_t;   // j/jal index field

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // funct field for r-type, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    localparam word_t NOP_WORD = 32'h0000_0000; // sll r0, r0, 0

endpackage

//--- hw/mips_pipe_pkg.sv
package mips_pipe_pkg;

    import mips_isa_pkg::*;

    // ALU_ADD is zero so a cleared control word is an add
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_LUI = 4'd7
    } alu_op_t;

    typedef struct packed {
        logic    reg_dst;     // dest is rd, else rt
        logic    alu_src;     // operand b from immediate
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    reg_write;
        logic    branch;
        logic    branch_ne;   // with branch, taken on not equal
        logic    jump;
        logic    jump_reg;
        logic    link;        // write pc+4 to rd
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc4;
    } fetch_t;

    typedef struct packed {
        ctrl_t     ctrl;
        logic      illegal;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        word_t     rd_data_a;
        word_t     rd_data_b;
        word_t     imm_ext;
        word_t     br_target;
        word_t     j_target;
        word_t     pc4;
    } id_ex_t;

endpackage

//--- hw/register_file.sv
`timescale 1ns/10ps

module register_file
    import mips_isa_pkg::*;
#(
    parameter bit WB_BYPASS = 1'b1
)(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_we,
    input  reg_addr_t i_wr_addr,
    input  word_t     i_wr_data,
    input  reg_addr_t i_rd_addr1,
    input  reg_addr_t i_rd_addr2,
    output word_t     o_rd_data1,
    output word_t     o_rd_data2
);

    word_t regs [32];

    // r0 is hardwired, bypass only for a real write
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (WB_BYPASS && i_we && (addr == i_wr_addr)) begin
            data = i_wr_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb begin
        o_rd_data1 = read_port(i_rd_addr1);
        o_rd_data2 = read_port(i_rd_addr2);
    end

endmodule

//--- tests/decode_patterns.hex
// instr pc4 ctl wb_data | expected: ctrl_ill fields rd_a rd_b imm br_tgt j_tgt pc4
// ctl = GG S F E 0 AA (group, stall, flush, wb_en, wb_addr); fields = rs rt rd shamt bytes
00000000 00000000 01001005 11112222 0000840A 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 01001006 AAAA5555 0000840A 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00A63820 00400004 01000000 00000000 0000840A 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00094020 00400008 01001009 0000BEEF 00008400 05060700 11112222 AAAA5555 00003820 0040E084 0298E080 00400004
016C5020 0040000C 01001000 FFFFFFFF 00008400 00090800 00000000 0000BEEF 00004020 00410088 00250080 00400008
00000000 00000000 0100100B 12345678 00008400 0B0C0A00 12345678 00000000 00005020 0041408C 05B14080 0040000C
00000000 00000000 01000000 00000000 0000840A 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00221822 00001000 02000000 00000000 0000840A 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00221824 00001000 02000000 00000000 00008402 01020300 00000000 00000000 00001822 00007088 00886088 00001000
00221825 00001000 02000000 00000000 00008404 01020300 00000000 00000000 00001824 00007090 00886090 00001000
0022182A 00001000 02000000 00000000 00008406 01020300 00000000 00000000 00001825 00007094 00886094 00001000
00021900 00001000 02000000 00000000 00008408 01020300 00000000 00000000 0000182A 000070A8 008860A8 00001000
00021FC2 00001000 02000000 00000000 0000840A 00020304 00000000 00000000 00001900 00007400 00086400 00001000
03E00008 00001000 02000000 00000000 0000840C 0002031F 00000000 00000000 00001FC2 00008F08 00087F08 00001000
2024FFFC 00001000 02000000 00000000 00000040 1F000000 00000000 00000000 00000008 00001020 0F800020 00001000
30248001 00001000 02000000 00000000 00004400 01041F1F 00000000 00000000 FFFFFFFC 00000FF0 0093FFF0 00001000
3424F00F 00001000 02000000 00000000 00004404 01041000 00000000 00000000 00008001 FFFE1004 00920004 00001000
3C04ABCD 00001000 02000000 00000000 00004406 01041E00 00000000 00000000 0000F00F FFFFD03C 0093C03C 00001000
8C24FFF8 00001000 02000000 00000000 0000440E 0004150F 00000000 00000000 0000ABCD FFFEBF34 0012AF34 00001000
AC227FFC 00001000 02000000 00000000 00006C00 01041F1F 00000000 00000000 FFFFFFF8 00000FE0 0093FFE0 00001000
1022FFFF 00001000 02000000 00000000 00005000 01020F1F 00000000 00000000 00007FFC 00020FF0 0089FFF0 00001000
14220003 00001000 02000000 00000000 00000202 01021F1F 00000000 00000000 FFFFFFFF 00000FFC 008BFFFC 00001000
08100000 90000010 02000000 00000000 00000302 01020000 00000000 00000000 00000003 0000100C 0088000C 00001000
0FFFFFFF F0000020 02000000 00000000 00000080 00100000 00000000 00000000 00000000 90000010 90400000 90000010
FC000000 00001000 02000000 00000000 000084A0 1F1F1F1F 00000000 00000000 FFFFFFFF F000001C FFFFFFFC F0000020
0000003F 00001000 02000000 00000000 00000001 00000000 00000000 00000000 00000000 00001000 00000000 00001000
00000000 00000000 02000000 00000000 00000001 00000000 00000000 00000000 0000003F 000010FC 000000FC 00001000
00A63820 00400004 03000000 00000000 0000840A 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2024FFFC 00001000 03100000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2024FFFC 00001000 03100000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2024FFFC 00001000 03000000 00000000 00008400 05060700 11112222 AAAA5555 00003820 0040E084 0298E080 00400004
00221822 00001000 03110000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00221822 00001000 03010000 00000000 00004400 01041F1F 00000000 00000000 FFFFFFFC 00000FF0 0093FFF0 00001000
00221822 00001000 03000000 00000000 0000840A 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 03000000 00000000 00008402 01020300 00000000 00000000 00001822 00007088 00886088 00001000

//--- tests/decode_sva.sv
`timescale 1ns/10ps

module decode_sva
    import mips_pipe_pkg::*;
(
    input logic   clk,
    input logic   i_rst_n,
    input logic   i_stall,
    input id_ex_t o_id_ex
);

    // a stalled edge loads a bubble
    stall_gives_bubble: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_stall |=> (o_id_ex.ctrl == '0)
    ) else $error("control bits active one cycle after a stall");

    illegal_has_no_ctrl: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_id_ex.illegal |-> (o_id_ex.ctrl == '0)
    ) else $error("illegal instruction carries active control bits");

    // first decode out of reset reads the cleared file
    reset_reads_zero: assert property (
        @(posedge clk)
        $rose(i_rst_n) |=> (o_id_ex.rd_data_a == '0 && o_id_ex.rd_data_b == '0)
    ) else $error("read data nonzero in the cycle after reset");

endmodule

bind decode_top decode_sva u_sva (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_stall (i_stall),
    .o_id_ex (o_id_ex)
);

//--- tests/tb_decode_top.sv
`timescale 1ns/10ps

module tb_decode_top
    import mips_isa_pkg::*, mips_pipe_pkg::*;
();

    localparam int COLS       = 12;   // tokens per pattern line
    localparam int MAX_LINES  = 64;
    localparam int WAIT_LIMIT = 20;

    logic      clk;
    logic      i_rst_n;
    fetch_t    i_fetch;
    logic      i_stall;
    logic      i_flush;
    logic      i_wb_en;
    reg_addr_t i_wb_addr;
    word_t     i_wb_data;
    id_ex_t    o_id_ex;

    word_t pat [COLS*MAX_LINES];
    string names [4] = '{"reset", "register file", "control and immediates", "stall and flush"};
    int    errors;
    int    checks;
    int    test_errors;
    int    test_checks;
    int    tests_run;
    logic  timed_out;

    decode_top #(
        .WB_BYPASS (1'b1)
    ) uut (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_fetch   (i_fetch),
        .i_stall   (i_stall),
        .i_flush   (i_flush),
        .i_wb_en   (i_wb_en),
        .i_wb_addr (i_wb_addr),
        .i_wb_data (i_wb_data),
        .o_id_ex   (o_id_ex)
    );

    always #5 clk = ~clk;

    initial begin
        #200000;
        $display("watchdog expired before the pattern run finished");
        $display("sim failed");
        $finish;
    end

    task automatic check_field(input string name, input word_t got, input word_t exp);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %08h expected %08h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_line(input int n);
        int b;
        b = n * COLS;
        check_field("o_id_ex.ctrl", 32'(o_id_ex.ctrl), 32'(pat[b+4][15:1]));
        check_field("o_id_ex.illegal", 32'(o_id_ex.illegal), 32'(pat[b+4][0]));
        check_field("o_id_ex.rs", 32'(o_id_ex.rs), 32'(pat[b+5][28:24]));
        check_field("o_id_ex.rt", 32'(o_id_ex.rt), 32'(pat[b+5][20:16]));
        check_field("o_id_ex.rd", 32'(o_id_ex.rd), 32'(pat[b+5][12:8]));
        check_field("o_id_ex.shamt", 32'(o_id_ex.shamt), 32'(pat[b+5][4:0]));
        check_field("o_id_ex.rd_data_a", o_id_ex.rd_data_a, pat[b+6]);
        check_field("o_id_ex.rd_data_b", o_id_ex.rd_data_b, pat[b+7]);
        check_field("o_id_ex.imm_ext", o_id_ex.imm_ext, pat[b+8]);
        check_field("o_id_ex.br_target", o_id_ex.br_target, pat[b+9]);
        check_field("o_id_ex.j_target", o_id_ex.j_target, pat[b+10]);
        check_field("o_id_ex.pc4", o_id_ex.pc4, pat[b+11]);
    endtask

    task automatic drive_line(input int n);
        int b;
        b = n * COLS;
        i_fetch.instr = pat[b];
        i_fetch.pc4   = pat[b+1];
        i_stall       = pat[b+2][20];
        i_flush       = pat[b+2][16];
        i_wb_en       = pat[b+2][12];
        i_wb_addr     = pat[b+2][4:0];
        i_wb_data     = pat[b+3];
    endtask

    task automatic drive_idle();
        i_fetch   = '0;
        i_stall   = 1'b0;
        i_flush   = 1'b0;
        i_wb_en   = 1'b0;
        i_wb_addr = '0;
        i_wb_data = '0;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // idle nops flush the previous group out of both registers
    task automatic wait_drained();
        int cnt;
        cnt = 0;
        while ((o_id_ex.pc4 != '0 || o_id_ex.imm_ext != '0) && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (o_id_ex.pc4 != '0 || o_id_ex.imm_ext != '0) begin
            $display("pipeline did not drain to a NOP within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int n;
        int idle;
        int seed_val;
        logic [7:0] grp;
        seed_val = $urandom(32'h94e9_0f7c);
        clk = 1'b0;
        i_rst_n = 1'b0;
        drive_idle();
        errors = 0;
        checks = 0;
        test_errors = 0;
        test_checks = 0;
        tests_run = 0;
        timed_out = 1'b0;
        for (int i = 0; i < COLS*MAX_LINES; i++) begin
            pat[i] = '1;   // group ff marks the end
        end
        $readmemh("tests/decode_patterns.hex", pat);

        repeat (4) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        checks++;
        test_checks++;
        assert (o_id_ex == '0) else begin
            $display("[FAIL] %0t o_id_ex got %h expected 0", $time, o_id_ex);
            errors++;
            test_errors++;
        end
        report_test(names[0]);

        n = 0;
        while (!timed_out && n < MAX_LINES && pat[n*COLS+2][31:24] != 8'hff) begin
            grp = pat[n*COLS+2][31:24];
            drive_line(n);
            @(posedge clk);
            #1;
            check_line(n);
            n++;
            if (n == MAX_LINES || pat[n*COLS+2][31:24] != grp) begin
                report_test(names[int'(grp)]);
                idle = int'($urandom_range(4, 2));
                drive_idle();
                repeat (idle) @(posedge clk);
                #1;
                wait_drained();
            end
        end

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
